/* rtl/mover_pkg.sv */
// Address, configuration word and sequencer state types of the data mover
// Register map of the host configuration block
`default_nettype none

package mover_pkg;

    // Every channel word carries two addresses of this width
    localparam int ADDR_WIDTH = 16;

    // Host registers are 32 bits wide and selected by an 8 bit index
    localparam int CFG_WORD_WIDTH = 32;
    localparam int CFG_ADDR_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [CFG_WORD_WIDTH-1:0] cfg_word_t;

    typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    // Index 0 holds the number of active channels
    localparam cfg_addr_t COUNT_REG = 8'd0;

    // Channel n lives at FIRST_CHANNEL_REG + n
    localparam cfg_addr_t FIRST_CHANNEL_REG = 8'd1;

    // Field positions inside a channel word
    // The source sits in the low half and the target in the high half
    localparam int SOURCE_LSB = 0;
    localparam int TARGET_LSB = 16;

    // Sequencer walks idle -> issue_request -> await_response and back
    typedef enum logic [1:0] {
        idle           = 2'd0,
        issue_request  = 2'd1,
        await_response = 2'd2
    } sequencer_state_t;

endpackage

`default_nettype wire

/* rtl/channel_config.sv */
// Host register block with the active channel count and channel address table
`timescale 1ns/10ps
`default_nettype none

module channel_config #(
    parameter int MAX_CHANNELS = 8,
    localparam int INDEX_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    cfg_write,
    input  mover_pkg::cfg_addr_t   cfg_address,
    input  mover_pkg::cfg_word_t   cfg_write_data,
    input  wire                    busy,
    output mover_pkg::cfg_word_t   cfg_read_data,
    output logic [INDEX_WIDTH:0]   channel_count,
    output mover_pkg::addr_t       source_table [MAX_CHANNELS],
    output mover_pkg::addr_t       target_table [MAX_CHANNELS]
);

    import mover_pkg::*;

    // One raw register word per channel
    cfg_word_t channel_words [MAX_CHANNELS];

    // Offset of the addressed register from the first channel word
    cfg_addr_t channel_slot;
    logic      in_table;

    assign channel_slot = cfg_address - FIRST_CHANNEL_REG;

    // Indices below the table or past its end hit no channel word
    assign in_table = (cfg_address >= FIRST_CHANNEL_REG) && (channel_slot < MAX_CHANNELS);

    // The table is frozen while a run is in progress
    always_ff @(posedge clock) begin
        if (!reset) begin
            channel_count <= '0;
            for (int n = 0; n < MAX_CHANNELS; n++) begin
                channel_words[n] <= '0;
            end
        end else if (cfg_write && !busy) begin
            if (cfg_address == COUNT_REG) begin
                // An oversized count would walk off the table, so it is discarded
                if (cfg_write_data <= MAX_CHANNELS) begin
                    channel_count <= cfg_write_data[INDEX_WIDTH:0];
                end
            end else if (in_table) begin
                channel_words[channel_slot[INDEX_WIDTH-1:0]] <= cfg_write_data;
            end
        end
    end

    // Readback mirrors the stored values, unmapped indices read as zero
    always_comb begin
        cfg_read_data = '0;
        if (cfg_address == COUNT_REG) begin
            cfg_read_data = cfg_word_t'(channel_count);
        end else if (in_table) begin
            cfg_read_data = channel_words[channel_slot[INDEX_WIDTH-1:0]];
        end
    end

    // Split each channel word into its two address fields
    always_comb begin
        for (int n = 0; n < MAX_CHANNELS; n++) begin
            source_table[n] = channel_words[n][SOURCE_LSB +: ADDR_WIDTH];
            target_table[n] = channel_words[n][TARGET_LSB +: ADDR_WIDTH];
        end
    end

    // The sequencer relies on the count never pointing past the table
    count_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        channel_count <= MAX_CHANNELS
    );

endmodule

`default_nettype wire

/* rtl/sample_store.sv */
// Host loaded source memory with a fixed latency pipelined read port
`timescale 1ns/10ps
`default_nettype none

module sample_store #(
    parameter int DATA_WIDTH    = 32,
    parameter int STORE_WORDS   = 256,
    parameter int STORE_LATENCY = 2
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    load_valid,
    input  mover_pkg::addr_t       load_address,
    input  wire [DATA_WIDTH-1:0]   load_data,
    input  wire                    request_valid,
    input  mover_pkg::addr_t       request_address,
    output logic                   response_valid,
    output logic [DATA_WIDTH-1:0]  response_data
);

    localparam int STORE_ADDR_WIDTH = $clog2(STORE_WORDS);

    logic [DATA_WIDTH-1:0] store_memory [STORE_WORDS];

    // Stage 0 holds the raw memory read, the last stage drives the response
    logic [STORE_LATENCY-1:0] valid_pipe;
    logic [DATA_WIDTH-1:0]    data_pipe [STORE_LATENCY];

    // Only the low address bits select a word
    // Higher bits simply wrap around the store
    always_ff @(posedge clock) begin
        if (load_valid) begin
            store_memory[load_address[STORE_ADDR_WIDTH-1:0]] <= load_data;
        end
    end

    // Nonblocking read at the same edge as a load returns the old word
    always_ff @(posedge clock) begin
        data_pipe[0] <= store_memory[request_address[STORE_ADDR_WIDTH-1:0]];
        for (int i = 1; i < STORE_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // Valid bits travel alongside the data so several reads can be in flight
    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= request_valid;
            for (int i = 1; i < STORE_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign response_valid = valid_pipe[STORE_LATENCY-1];
    assign response_data  = data_pipe[STORE_LATENCY-1];

    // Every request is answered exactly STORE_LATENCY cycles later
    request_answered: assert property (
        @(posedge clock) disable iff (!reset)
        request_valid |-> ##STORE_LATENCY response_valid
    );

endmodule

`default_nettype wire

/* rtl/channel_sequencer.sv */
// Channel walking FSM that requests source words and emits them tagged with
// their target address
`timescale 1ns/10ps
`default_nettype none

module channel_sequencer #(
    parameter int DATA_WIDTH   = 32,
    parameter int MAX_CHANNELS = 8,
    localparam int INDEX_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    start,
    input  wire [INDEX_WIDTH:0]    channel_count,
    input  mover_pkg::addr_t       source_table [MAX_CHANNELS],
    input  mover_pkg::addr_t       target_table [MAX_CHANNELS],
    input  wire                    response_valid,
    input  wire [DATA_WIDTH-1:0]   response_data,
    output logic                   busy,
    output logic                   request_valid,
    output mover_pkg::addr_t       request_address,
    output logic                   move_valid,
    output logic [DATA_WIDTH-1:0]  move_data,
    output mover_pkg::addr_t       move_target
);

    import mover_pkg::*;

    sequencer_state_t state;

    // Channel currently being served
    logic [INDEX_WIDTH-1:0] channel_index;

    // One past the current channel, wide enough to compare against the count
    logic [INDEX_WIDTH:0] next_index;
    logic                 last_channel;

    assign next_index   = {1'b0, channel_index} + 1'b1;
    assign last_channel = (next_index == channel_count);

    // Busy covers the whole walk plus the cycle of the final move pulse
    assign busy = (state != idle) || move_valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state         <= idle;
            channel_index <= '0;
            request_valid <= 1'b0;
            move_valid    <= 1'b0;
        end else begin
            // Both outputs are single cycle pulses
            request_valid <= 1'b0;
            move_valid    <= 1'b0;
            case (state)
                idle: begin
                    // A zero count or a start during the final pulse does nothing
                    if (start && !busy && (channel_count != '0)) begin
                        state <= issue_request;
                    end
                end
                issue_request: begin
                    request_valid <= 1'b1;
                    state         <= await_response;
                end
                await_response: begin
                    if (response_valid) begin
                        move_valid <= 1'b1;
                        if (last_channel) begin
                            channel_index <= '0;
                            state         <= idle;
                        end else begin
                            channel_index <= next_index[INDEX_WIDTH-1:0];
                            state         <= issue_request;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Address of the request, valid while request_valid is high
    always_ff @(posedge clock) begin
        if (state == issue_request) begin
            request_address <= source_table[channel_index];
        end
    end

    // Emitted word and its tag are captured from the response cycle
    always_ff @(posedge clock) begin
        if ((state == await_response) && response_valid) begin
            move_data   <= response_data;
            move_target <= target_table[channel_index];
        end
    end

    // A request pulse always serves a channel inside the active count,
    // which relies on the count staying frozen during the walk
    request_in_active_channel: assert property (
        @(posedge clock) disable iff (!reset)
        request_valid |-> ({1'b0, channel_index} < channel_count)
    );

    // The store only answers requests, so nothing may come back while idle
    no_response_in_idle: assert property (
        @(posedge clock) disable iff (!reset)
        response_valid |-> (state == await_response)
    );

endmodule

`default_nettype wire

/* rtl/target_bank.sv */
// Destination memory that records moved words by target and serves host reads
`timescale 1ns/10ps
`default_nettype none

module target_bank #(
    parameter int DATA_WIDTH = 32,
    parameter int BANK_WORDS = 256
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    move_valid,
    input  wire [DATA_WIDTH-1:0]   move_data,
    input  mover_pkg::addr_t       move_target,
    input  mover_pkg::addr_t       bank_read_address,
    output logic [DATA_WIDTH-1:0]  bank_read_data
);

    localparam int BANK_ADDR_WIDTH = $clog2(BANK_WORDS);

    // Every destination word starts out as zero after reset
    logic [DATA_WIDTH-1:0] bank_memory [BANK_WORDS];

    // Targets wrap on the low address bits
    logic [BANK_ADDR_WIDTH-1:0] write_slot;
    logic [BANK_ADDR_WIDTH-1:0] read_slot;

    assign write_slot = move_target[BANK_ADDR_WIDTH-1:0];
    assign read_slot  = bank_read_address[BANK_ADDR_WIDTH-1:0];

    // A later move to the same slot overwrites the earlier one
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < BANK_WORDS; i++) begin
                bank_memory[i] <= '0;
            end
        end else if (move_valid) begin
            bank_memory[write_slot] <= move_data;
        end
    end

    // Host readback has no latency
    assign bank_read_data = bank_memory[read_slot];

endmodule

`default_nettype wire

/* rtl/data_mover_top.sv */
// Top level of the data mover with config block, sample store, sequencer
// and target bank
`timescale 1ns/10ps
`default_nettype none

module data_mover_top #(
    parameter int DATA_WIDTH    = 32,
    parameter int MAX_CHANNELS  = 8,
    parameter int STORE_WORDS   = 256,
    parameter int BANK_WORDS    = 256,
    parameter int STORE_LATENCY = 2,
    localparam int INDEX_WIDTH  = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    cfg_write,
    input  mover_pkg::cfg_addr_t   cfg_address,
    input  mover_pkg::cfg_word_t   cfg_write_data,
    output mover_pkg::cfg_word_t   cfg_read_data,
    input  wire                    load_valid,
    input  mover_pkg::addr_t       load_address,
    input  wire [DATA_WIDTH-1:0]   load_data,
    input  wire                    start,
    input  mover_pkg::addr_t       bank_read_address,
    output logic                   busy,
    output logic                   move_valid,
    output logic [DATA_WIDTH-1:0]  move_data,
    output mover_pkg::addr_t       move_target,
    output logic [DATA_WIDTH-1:0]  bank_read_data
);

    import mover_pkg::*;

    // Channel table from the register block to the sequencer
    logic [INDEX_WIDTH:0] channel_count;
    addr_t                source_table [MAX_CHANNELS];
    addr_t                target_table [MAX_CHANNELS];

    // Read path between the sequencer and the sample store
    logic                  request_valid;
    addr_t                 request_address;
    logic                  response_valid;
    logic [DATA_WIDTH-1:0] response_data;

    channel_config #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) config_i (
        .clock(clock),
        .reset(reset),
        .cfg_write(cfg_write),
        .cfg_address(cfg_address),
        .cfg_write_data(cfg_write_data),
        .busy(busy),
        .cfg_read_data(cfg_read_data),
        .channel_count(channel_count),
        .source_table(source_table),
        .target_table(target_table)
    );

    sample_store #(
        .DATA_WIDTH(DATA_WIDTH),
        .STORE_WORDS(STORE_WORDS),
        .STORE_LATENCY(STORE_LATENCY)
    ) store_i (
        .clock(clock),
        .reset(reset),
        .load_valid(load_valid),
        .load_address(load_address),
        .load_data(load_data),
        .request_valid(request_valid),
        .request_address(request_address),
        .response_valid(response_valid),
        .response_data(response_data)
    );

    channel_sequencer #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) sequencer_i (
        .clock(clock),
        .reset(reset),
        .start(start),
        .channel_count(channel_count),
        .source_table(source_table),
        .target_table(target_table),
        .response_valid(response_valid),
        .response_data(response_data),
        .busy(busy),
        .request_valid(request_valid),
        .request_address(request_address),
        .move_valid(move_valid),
        .move_data(move_data),
        .move_target(move_target)
    );

    // The bank taps the same stream that leaves the top level
    target_bank #(
        .DATA_WIDTH(DATA_WIDTH),
        .BANK_WORDS(BANK_WORDS)
    ) bank_i (
        .clock(clock),
        .reset(reset),
        .move_valid(move_valid),
        .move_data(move_data),
        .move_target(move_target),
        .bank_read_address(bank_read_address),
        .bank_read_data(bank_read_data)
    );

endmodule

`default_nettype wire

/* dv/data_mover_tb.sv */
// Directed testbench for the data mover with LFSR stimulus, reference model,
// compare tasks, six tests and a watchdog
`timescale 1ns/10ps
`default_nettype none

module data_mover_tb;

    import mover_pkg::*;

    localparam int DATA_WIDTH       = 32;
    localparam int MAX_CHANNELS     = 8;
    localparam int STORE_WORDS      = 256;
    localparam int BANK_WORDS       = 256;
    localparam int STORE_LATENCY    = 2;
    localparam int STORE_ADDR_WIDTH = $clog2(STORE_WORDS);
    localparam int BANK_ADDR_WIDTH  = $clog2(BANK_WORDS);
    localparam int CLOCK_PERIOD     = 4;
    localparam int RESET_CYCLES     = 16;
    localparam int CFG_SPAN         = 2 ** CFG_ADDR_WIDTH;

    // Cycles from one request to the next, and the first pulse lands one later than a spacing
    localparam int SPACING   = STORE_LATENCY + 2;
    localparam int RUN_SLACK = 4;
    localparam int FULL_RUN  = MAX_CHANNELS * SPACING + 1 + RUN_SLACK;

    // Worst case of each test in cycles: readback, single, multi, count, busy, wrap
    localparam int TEST_CYCLES = (2 * CFG_SPAN + BANK_WORDS + 2 * (MAX_CHANNELS + 3))
        + (7 + FULL_RUN) + (5 * MAX_CHANNELS + 2 + FULL_RUN) + (10 + FULL_RUN)
        + (4 + FULL_RUN + MAX_CHANNELS) + (7 + FULL_RUN);

    logic                  clock;
    logic                  reset;
    logic                  cfg_write;
    cfg_addr_t             cfg_address;
    cfg_word_t             cfg_write_data;
    cfg_word_t             cfg_read_data;
    logic                  load_valid;
    addr_t                 load_address;
    logic [DATA_WIDTH-1:0] load_data;
    logic                  start;
    addr_t                 bank_read_address;
    logic                  busy;
    logic                  move_valid;
    logic [DATA_WIDTH-1:0] move_data;
    addr_t                 move_target;
    logic [DATA_WIDTH-1:0] bank_read_data;

    // Reference model of the store, the bank and the register table
    logic [DATA_WIDTH-1:0] store_model [STORE_WORDS];
    logic [DATA_WIDTH-1:0] bank_model [BANK_WORDS];
    cfg_word_t             table_model [MAX_CHANNELS];
    cfg_word_t             count_model;

    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          errors_before_test;
    logic [15:0] lfsr_state;

    data_mover_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS),
        .STORE_WORDS(STORE_WORDS),
        .BANK_WORDS(BANK_WORDS),
        .STORE_LATENCY(STORE_LATENCY)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .cfg_write(cfg_write),
        .cfg_address(cfg_address),
        .cfg_write_data(cfg_write_data),
        .cfg_read_data(cfg_read_data),
        .load_valid(load_valid),
        .load_address(load_address),
        .load_data(load_data),
        .start(start),
        .bank_read_address(bank_read_address),
        .busy(busy),
        .move_valid(move_valid),
        .move_data(move_data),
        .move_target(move_target),
        .bank_read_data(bank_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Twice the summed worst case of all tests, on top of reset
    initial begin
        #((2 * TEST_CYCLES + RESET_CYCLES) * CLOCK_PERIOD);
        $display("Timeout: the tests did not complete within the expected run time");
        $display("Something failed");
        $finish;
    end

    // Galois LFSR with taps 16,14,13,11, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // Readback expected from the register map
    function automatic cfg_word_t expected_cfg(input int index);
        if (index == COUNT_REG) begin
            return count_model;
        end
        if ((index >= FIRST_CHANNEL_REG) && (index - FIRST_CHANNEL_REG < MAX_CHANNELS)) begin
            return table_model[index - FIRST_CHANNEL_REG];
        end
        return '0;
    endfunction

    task automatic report_mismatch(input string message);
        $display("MISMATCH at %0t: %s", $time, message);
        error_count++;
    endtask

    task automatic cfg_word_equal(input cfg_word_t actual, input cfg_word_t expected,
                                  input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic data_equal(input logic [DATA_WIDTH-1:0] actual,
                              input logic [DATA_WIDTH-1:0] expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic target_equal(input addr_t actual, input addr_t expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic level_equal(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic count_equal(input int actual, input int expected, input string what);
        if (actual != expected) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, actual, expected))
            ;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == errors_before_test) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name,
                     error_count - errors_before_test);
        end
        errors_before_test = error_count;
    endtask

    // Register write while idle, so the model applies the count and range guards
    task automatic write_cfg(input cfg_addr_t index, input cfg_word_t data);
        @(negedge clock);
        cfg_write      = 1'b1;
        cfg_address    = index;
        cfg_write_data = data;
        @(negedge clock);
        cfg_write = 1'b0;
        if (index == COUNT_REG) begin
            if (data <= MAX_CHANNELS) begin
                count_model = data;
            end
        end else if ((index >= FIRST_CHANNEL_REG) &&
                     (index - FIRST_CHANNEL_REG < MAX_CHANNELS)) begin
            table_model[index - FIRST_CHANNEL_REG] = data;
        end
    endtask

    task automatic load_sample(input addr_t address, input logic [DATA_WIDTH-1:0] data);
        @(negedge clock);
        load_valid   = 1'b1;
        load_address = address;
        load_data    = data;
        @(negedge clock);
        load_valid = 1'b0;
        store_model[address[STORE_ADDR_WIDTH-1:0]] = data;
    endtask

    // Readback is combinational and sampled well before the next rising edge
    task automatic read_cfg(input cfg_addr_t index, output cfg_word_t value);
        @(negedge clock);
        cfg_address = index;
        #1;
        value = cfg_read_data;
    endtask

    task automatic read_bank(input addr_t address, output logic [DATA_WIDTH-1:0] value);
        @(negedge clock);
        bank_read_address = address;
        #1;
        value = bank_read_data;
    endtask

    task automatic verify_cfg_range(input int index_count);
        cfg_word_t value;
        for (int index = 0; index < index_count; index++) begin
            read_cfg(cfg_addr_t'(index), value);
            cfg_word_equal(value, expected_cfg(index), $sformatf("register %0d", index));
        end
    endtask

    // Pulses start and checks every cycle of the run against the timing rules
    // With disturb set, it also writes registers and pulses start during the run
    task automatic run_and_collect(input bit disturb);
        logic [DATA_WIDTH-1:0] expected_data [MAX_CHANNELS];
        addr_t                 expected_target [MAX_CHANNELS];
        int                    channels;
        int                    last_cycle;
        int                    limit;
        int                    pulses;
        channels = int'(count_model);
        for (int ch = 0; ch < channels; ch++) begin
            expected_data[ch]   = store_model[table_model[ch][STORE_ADDR_WIDTH-1:0]];
            expected_target[ch] = table_model[ch][31:16];
        end
        last_cycle = channels * SPACING + 1;
        limit      = (channels == 0) ? 2 * SPACING + RUN_SLACK : last_cycle + RUN_SLACK;
        pulses     = 0;
        @(negedge clock);
        start = 1'b1;
        for (int cycle = 1; cycle <= limit; cycle++) begin
            @(negedge clock);
            start     = 1'b0;
            cfg_write = 1'b0;
            if (disturb) begin
                if (cycle == 2) begin
                    cfg_write      = 1'b1;
                    cfg_address    = COUNT_REG;
                    cfg_write_data = 32'd1;
                end
                if (cycle == 4) begin
                    cfg_write      = 1'b1;
                    cfg_address    = FIRST_CHANNEL_REG;
                    cfg_write_data = ~table_model[0];
                end
                // Second starts mid run and on the final pulse
                if ((cycle == 3) || (cycle == last_cycle)) begin
                    start = 1'b1;
                end
            end
            #1;
            level_equal(busy, (channels > 0) && (cycle <= last_cycle),
                        $sformatf("busy in cycle %0d", cycle));
            if (move_valid) begin
                if (pulses < channels) begin
                    count_equal(cycle, (pulses + 1) * SPACING + 1,
                                $sformatf("cycle of pulse %0d", pulses));
                    data_equal(move_data, expected_data[pulses],
                               $sformatf("move_data of channel %0d", pulses));
                    target_equal(move_target, expected_target[pulses],
                                 $sformatf("move_target of channel %0d", pulses));
                    bank_model[expected_target[pulses][BANK_ADDR_WIDTH-1:0]] =
                        expected_data[pulses];
                end
                pulses++;
            end
        end
        count_equal(pulses, channels, "number of move pulses");
    endtask

    task automatic reset_readback;
        logic [DATA_WIDTH-1:0] word;
        level_equal(busy, 1'b0, "busy after reset");
        level_equal(move_valid, 1'b0, "move_valid after reset");
        verify_cfg_range(CFG_SPAN);
        for (int i = 0; i < BANK_WORDS; i++) begin
            read_bank(addr_t'(i), word);
            data_equal(word, bank_model[i], $sformatf("bank word %0d after reset", i));
        end
        for (int ch = 0; ch < MAX_CHANNELS; ch++) begin
            write_cfg(cfg_addr_t'(FIRST_CHANNEL_REG + ch), random_bits(32));
        end
        write_cfg(COUNT_REG, 32'd5);
        // Both indices lie past the table and hold nothing
        write_cfg(cfg_addr_t'(FIRST_CHANNEL_REG + MAX_CHANNELS), random_bits(32));
        write_cfg(cfg_addr_t'(200), random_bits(32));
        verify_cfg_range(CFG_SPAN);
        finish_test("reset and readback");
    endtask

    task automatic single_channel_move;
        addr_t                 source;
        addr_t                 target;
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] word;
        source = addr_t'(random_bits(STORE_ADDR_WIDTH));
        target = addr_t'(random_bits(BANK_ADDR_WIDTH));
        data   = random_bits(DATA_WIDTH);
        load_sample(source, data);
        write_cfg(FIRST_CHANNEL_REG, {target, source});
        write_cfg(COUNT_REG, 32'd1);
        run_and_collect(1'b0);
        read_bank(target, word);
        data_equal(word, data, "bank word of the single channel");
        finish_test("single channel move");
    endtask

    task automatic multi_channel_order;
        addr_t                 source;
        addr_t                 target;
        logic [DATA_WIDTH-1:0] word;
        for (int ch = 0; ch < MAX_CHANNELS; ch++) begin
            source = addr_t'(random_bits(STORE_ADDR_WIDTH));
            target = addr_t'(random_bits(16));
            // The last channel reuses channel 1's target, so it must win there
            if (ch == MAX_CHANNELS - 1) begin
                target = table_model[1][31:16];
            end
            load_sample(source, random_bits(DATA_WIDTH));
            write_cfg(cfg_addr_t'(FIRST_CHANNEL_REG + ch), {target, source});
        end
        write_cfg(COUNT_REG, MAX_CHANNELS);
        run_and_collect(1'b0);
        for (int ch = 0; ch < MAX_CHANNELS; ch++) begin
            target = table_model[ch][31:16];
            read_bank(target, word);
            data_equal(word, bank_model[target[BANK_ADDR_WIDTH-1:0]],
                       $sformatf("bank word at target of channel %0d", ch));
        end
        finish_test("multi-channel order");
    endtask

    task automatic count_guards;
        cfg_word_t value;
        write_cfg(COUNT_REG, 32'd3);
        write_cfg(COUNT_REG, MAX_CHANNELS + 1);
        // Low bits alone would look like a legal count
        write_cfg(COUNT_REG, 32'hFFFF_0004);
        read_cfg(COUNT_REG, value);
        cfg_word_equal(value, count_model, "count after oversized writes");
        write_cfg(COUNT_REG, 32'd0);
        read_cfg(COUNT_REG, value);
        cfg_word_equal(value, count_model, "count after writing zero");
        run_and_collect(1'b0);
        finish_test("count guards");
    endtask

    task automatic busy_guards;
        write_cfg(COUNT_REG, 32'd2);
        run_and_collect(1'b1);
        verify_cfg_range(MAX_CHANNELS + 2);
        finish_test("busy guards");
    endtask

    task automatic address_wrap;
        addr_t                 low_source;
        addr_t                 target;
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] word;
        low_source = addr_t'(random_bits(STORE_ADDR_WIDTH));
        target     = addr_t'(random_bits(BANK_ADDR_WIDTH) + BANK_WORDS * 9);
        data       = random_bits(DATA_WIDTH);
        load_sample(low_source, data);
        write_cfg(FIRST_CHANNEL_REG, {target, addr_t'(low_source + STORE_WORDS * 5)});
        write_cfg(COUNT_REG, 32'd1);
        run_and_collect(1'b0);
        read_bank(addr_t'(target % BANK_WORDS), word);
        data_equal(word, data, "bank word at the wrapped target");
        finish_test("store address wrap");
    endtask

    initial begin
        reset             = 1'b0;
        cfg_write         = 1'b0;
        cfg_address       = '0;
        cfg_write_data    = '0;
        load_valid        = 1'b0;
        load_address      = '0;
        load_data         = '0;
        start             = 1'b0;
        bank_read_address = '0;
        lfsr_state        = 16'd74;
        error_count        = 0;
        tests_run          = 0;
        tests_failed       = 0;
        errors_before_test = 0;
        count_model        = '0;
        for (int i = 0; i < STORE_WORDS; i++) begin
            store_model[i] = '0;
        end
        for (int i = 0; i < BANK_WORDS; i++) begin
            bank_model[i] = '0;
        end
        for (int i = 0; i < MAX_CHANNELS; i++) begin
            table_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        reset_readback();
        single_channel_move();
        multi_channel_order();
        count_guards();
        busy_guards();
        address_wrap();
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/mover_pkg.sv
rtl/channel_config.sv
rtl/sample_store.sv
rtl/channel_sequencer.sv
rtl/target_bank.sv
rtl/data_mover_top.sv
dv/data_mover_tb.sv
